//--- design/vrf_pkg.sv
`default_nettype none

package vrf_pkg;

   // one vector element, also one memory word
   typedef logic [31:0] elem_t;

   typedef logic [4:0] vreg_idx_t;

   // enough for VLEN up to 8192
   typedef logic [7:0] elem_idx_t;

   // element count of a load, up to 256
   typedef logic [8:0] vl_count_t;

   typedef logic [31:0] mem_addr_t;

   // names one element of one vector register
   typedef struct packed {
      vreg_idx_t vreg;
      elem_idx_t elem;
   } vrf_addr_t;

   // one write request, enable travels beside it
   typedef struct packed {
      vrf_addr_t addr;
      elem_t     data;
   } vrf_wr_t;

   // load command: destination, byte base, element count
   typedef struct packed {
      vreg_idx_t vreg;
      mem_addr_t base;
      vl_count_t count;
   } ld_cmd_t;

endpackage

`default_nettype wire

//--- design/vrf_bank_ram.sv
`timescale 1ns/1ns
`default_nettype none

module vrf_bank_ram #(
   parameter int DEPTH = 128
) (
   input  wire logic                     clk,
   input  wire logic                     we,
   input  wire logic [$clog2(DEPTH)-1:0] waddr,
   input  wire vrf_pkg::elem_t           wdata,
   input  wire logic                     re,
   input  wire logic [$clog2(DEPTH)-1:0] raddr,
   output vrf_pkg::elem_t                rdata
);

   vrf_pkg::elem_t mem [DEPTH];

   always_ff @(posedge clk)
   begin
      if (we)
      begin
         mem[waddr] <= wdata;
      end
   end

   // registered read port
   // on an address collision the word from before the write comes out
   always_ff @(posedge clk)
   begin
      if (re)
      begin
         rdata <= mem[raddr];
      end
   end

endmodule

`default_nettype wire

//--- design/lvt_table.sv
`timescale 1ns/1ns
`default_nettype none

module lvt_table #(
   parameter int DEPTH = 128
) (
   input  wire logic                     clk,
   input  wire logic                     rst_n,
   input  wire logic                     we0,
   input  wire logic [$clog2(DEPTH)-1:0] waddr0,
   input  wire logic                     we1,
   input  wire logic [$clog2(DEPTH)-1:0] waddr1,
   input  wire logic                     re0,
   input  wire logic [$clog2(DEPTH)-1:0] raddr0,
   input  wire logic                     re1,
   input  wire logic [$clog2(DEPTH)-1:0] raddr1,
   output logic                          sel0,
   output logic                          sel1
);

   // one bit per word, set means write port 1 holds the live copy
   logic [DEPTH-1:0] live;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         live <= '0;
         sel0 <= 1'b0;
         sel1 <= 1'b0;
      end
      else
      begin
         if (we0)
            live[waddr0] <= 1'b0;
         // port 1 comes second, so it wins a same-word collision
         if (we1)
            live[waddr1] <= 1'b1;
         // read in step with the bank read registers
         if (re0)
            sel0 <= live[raddr0];
         if (re1)
            sel1 <= live[raddr1];
      end
   end

   // banks take writes during reset but the table does not,
   // a collision there would leave the ports out of step
   a_no_collision_in_reset: assert property (@(posedge clk)
      !rst_n |-> !(we0 && we1 && (waddr0 == waddr1)));

endmodule

`default_nettype wire

//--- design/vrf_lane.sv
`timescale 1ns/1ns
`default_nettype none

module vrf_lane #(
   parameter int DEPTH = 128
) (
   input  wire logic                     clk,
   input  wire logic                     rst_n,
   input  wire logic                     we0,
   input  wire logic [$clog2(DEPTH)-1:0] waddr0,
   input  wire vrf_pkg::elem_t           wdata0,
   input  wire logic                     we1,
   input  wire logic [$clog2(DEPTH)-1:0] waddr1,
   input  wire vrf_pkg::elem_t           wdata1,
   input  wire logic                     re0,
   input  wire logic [$clog2(DEPTH)-1:0] raddr0,
   input  wire logic                     re1,
   input  wire logic [$clog2(DEPTH)-1:0] raddr1,
   output vrf_pkg::elem_t                rdata0,
   output vrf_pkg::elem_t                rdata1
);

   typedef logic [$clog2(DEPTH)-1:0] word_t;

   logic [1:0]     we_v;
   logic [1:0]     re_v;
   word_t          waddr_a [2];
   word_t          raddr_a [2];
   vrf_pkg::elem_t wdata_a [2];
   // indexed [write port][read port]
   vrf_pkg::elem_t bank_rdata [2][2];
   logic           sel0;
   logic           sel1;

   assign we_v       = {we1, we0};
   assign re_v       = {re1, re0};
   assign waddr_a[0] = waddr0;
   assign waddr_a[1] = waddr1;
   assign wdata_a[0] = wdata0;
   assign wdata_a[1] = wdata1;
   assign raddr_a[0] = raddr0;
   assign raddr_a[1] = raddr1;

   // each write port keeps a private copy per read port
   for (genvar wp = 0; wp < 2; wp++)
   begin : g_wp
      for (genvar rp = 0; rp < 2; rp++)
      begin : g_rp
         vrf_bank_ram #(.DEPTH(DEPTH)) bank_inst (
            .clk   (clk),
            .we    (we_v[wp]),
            .waddr (waddr_a[wp]),
            .wdata (wdata_a[wp]),
            .re    (re_v[rp]),
            .raddr (raddr_a[rp]),
            .rdata (bank_rdata[wp][rp])
         );
      end
   end

   lvt_table #(.DEPTH(DEPTH)) lvt_inst (
      .clk    (clk),
      .rst_n  (rst_n),
      .we0    (we0),
      .waddr0 (waddr0),
      .we1    (we1),
      .waddr1 (waddr1),
      .re0    (re0),
      .raddr0 (raddr0),
      .re1    (re1),
      .raddr1 (raddr1),
      .sel0   (sel0),
      .sel1   (sel1)
   );

   // pick the bank of whichever port wrote the word last
   assign rdata0 = sel0 ? bank_rdata[1][0] : bank_rdata[0][0];
   assign rdata1 = sel1 ? bank_rdata[1][1] : bank_rdata[0][1];

endmodule

`default_nettype wire

//--- design/vector_register_file.sv
`timescale 1ns/1ns
`default_nettype none

module vector_register_file #(
   parameter int VLEN    = 512,
   parameter int V_LANES = 4
) (
   input  wire logic               clk,
   input  wire logic               rst_n,
   input  wire logic               wr_en,
   input  wire vrf_pkg::vrf_wr_t   wr,
   input  wire logic               ld_wr_en,
   input  wire vrf_pkg::vrf_wr_t   ld_wr,
   input  wire logic               rd0_en,
   input  wire vrf_pkg::vrf_addr_t rd0_addr,
   input  wire logic               rd1_en,
   input  wire vrf_pkg::vrf_addr_t rd1_addr,
   output vrf_pkg::elem_t          rd0_data,
   output vrf_pkg::elem_t          rd1_data
);

   localparam int ELEMS         = VLEN / 32;
   localparam int WORDS_PER_REG = ELEMS / V_LANES;
   localparam int LANE_DEPTH    = 32 * WORDS_PER_REG;
   localparam int LANE_BITS     = $clog2(V_LANES);
   localparam int WORD_BITS     = $clog2(LANE_DEPTH);

   typedef logic [LANE_BITS-1:0] lane_t;
   typedef logic [WORD_BITS-1:0] lane_word_t;

   // element e sits in lane e mod V_LANES
   function automatic lane_t lane_of(vrf_pkg::vrf_addr_t a);
      return a.elem[LANE_BITS-1:0];
   endfunction

   function automatic lane_word_t word_of(vrf_pkg::vrf_addr_t a);
      return lane_word_t'(int'(a.vreg) * WORDS_PER_REG + int'(a.elem >> LANE_BITS));
   endfunction

   lane_t          wr_lane;
   lane_t          ld_lane;
   lane_t          rd0_lane;
   lane_t          rd1_lane;
   lane_word_t     wr_word;
   lane_word_t     ld_word;
   lane_word_t     rd0_word;
   lane_word_t     rd1_word;
   lane_t          rd0_lane_q;
   lane_t          rd1_lane_q;
   logic           rd0_valid_q;
   logic           rd1_valid_q;
   vrf_pkg::elem_t lane_rdata0 [V_LANES];
   vrf_pkg::elem_t lane_rdata1 [V_LANES];

   assign wr_lane  = lane_of(wr.addr);
   assign ld_lane  = lane_of(ld_wr.addr);
   assign rd0_lane = lane_of(rd0_addr);
   assign rd1_lane = lane_of(rd1_addr);
   assign wr_word  = word_of(wr.addr);
   assign ld_word  = word_of(ld_wr.addr);
   assign rd0_word = word_of(rd0_addr);
   assign rd1_word = word_of(rd1_addr);

   // addresses go to every lane, enables only to the target
   for (genvar l = 0; l < V_LANES; l++)
   begin : g_lane
      vrf_lane #(.DEPTH(LANE_DEPTH)) lane_inst (
         .clk    (clk),
         .rst_n  (rst_n),
         .we0    (wr_en && (wr_lane == lane_t'(l))),
         .waddr0 (wr_word),
         .wdata0 (wr.data),
         .we1    (ld_wr_en && (ld_lane == lane_t'(l))),
         .waddr1 (ld_word),
         .wdata1 (ld_wr.data),
         .re0    (rd0_en && (rd0_lane == lane_t'(l))),
         .raddr0 (rd0_word),
         .re1    (rd1_en && (rd1_lane == lane_t'(l))),
         .raddr1 (rd1_word),
         .rdata0 (lane_rdata0[l]),
         .rdata1 (lane_rdata1[l])
      );
   end

   // lane select follows the bank read by one cycle
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         rd0_valid_q <= 1'b0;
         rd1_valid_q <= 1'b0;
         rd0_lane_q  <= '0;
         rd1_lane_q  <= '0;
      end
      else
      begin
         if (rd0_en)
         begin
            rd0_valid_q <= 1'b1;
            rd0_lane_q  <= rd0_lane;
         end
         if (rd1_en)
         begin
            rd1_valid_q <= 1'b1;
            rd1_lane_q  <= rd1_lane;
         end
      end
   end

   // zero until the first read, then held until the next one
   assign rd0_data = rd0_valid_q ? lane_rdata0[rd0_lane_q] : '0;
   assign rd1_data = rd1_valid_q ? lane_rdata1[rd1_lane_q] : '0;

   a_elem_in_range: assert property (@(posedge clk) disable iff (!rst_n)
      (!wr_en || (wr.addr.elem < ELEMS)) && (!ld_wr_en || (ld_wr.addr.elem < ELEMS)) &&
      (!rd0_en || (rd0_addr.elem < ELEMS)) && (!rd1_en || (rd1_addr.elem < ELEMS)));

endmodule

`default_nettype wire

//--- design/vector_load_unit.sv
`timescale 1ns/1ns
`default_nettype none

module vector_load_unit (
   input  wire logic             clk,
   input  wire logic             rst_n,
   input  wire logic             ld_req,
   input  wire vrf_pkg::ld_cmd_t ld_cmd,
   output logic                  ld_ack,
   output logic                  mem_req,
   output vrf_pkg::mem_addr_t    mem_addr,
   input  wire logic             mem_ack,
   input  wire vrf_pkg::elem_t   mem_rdata,
   output logic                  ld_wr_en,
   output vrf_pkg::vrf_wr_t      ld_wr
);

   typedef enum logic [1:0] {
      idle,
      request,
      wait_release,
      finish
   } state_t;

   state_t             state;
   vrf_pkg::vreg_idx_t vreg_q;
   vrf_pkg::vl_count_t count_q;
   vrf_pkg::elem_idx_t elem_q;
   vrf_pkg::mem_addr_t addr_q;
   vrf_pkg::elem_t     data_q;
   logic               last_elem;

   assign last_elem = (vrf_pkg::vl_count_t'(elem_q) + vrf_pkg::vl_count_t'(1)) == count_q;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state <= idle;
      end
      else
      begin
         case (state)
            idle:
               // an empty load acknowledges at once
               if (ld_req)
                  state <= (ld_cmd.count == '0) ? finish : request;
            request:
               if (mem_ack)
                  state <= wait_release;
            wait_release:
               if (!mem_ack)
                  state <= last_elem ? finish : request;
            finish:
               if (!ld_req)
                  state <= idle;
            default:
               state <= idle;
         endcase
      end
   end

   // command fields, element counter, word address and captured data
   always_ff @(posedge clk)
   begin
      if ((state == idle) && ld_req)
      begin
         vreg_q  <= ld_cmd.vreg;
         count_q <= ld_cmd.count;
         elem_q  <= '0;
         addr_q  <= ld_cmd.base;
      end
      if ((state == request) && mem_ack)
      begin
         data_q <= mem_rdata;
      end
      // step on the same edge that writes the element
      if ((state == wait_release) && !mem_ack)
      begin
         elem_q <= elem_q + 1'b1;
         addr_q <= addr_q + 32'd4;
      end
   end

   assign mem_req  = (state == request);
   assign mem_addr = addr_q;
   assign ld_ack   = (state == finish);

   // element i lands when the memory has released word i
   assign ld_wr_en        = (state == wait_release) && !mem_ack;
   assign ld_wr.addr.vreg = vreg_q;
   assign ld_wr.addr.elem = elem_q;
   assign ld_wr.data      = data_q;

   // request and address hold until the memory answers
   a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
      mem_req && !mem_ack |=> mem_req && $stable(mem_addr));

endmodule

`default_nettype wire

//--- design/vrf_subsystem_top.sv
`timescale 1ns/1ns
`default_nettype none

module vrf_subsystem_top #(
   parameter int VLEN    = 512,
   parameter int V_LANES = 4
) (
   input  wire logic               clk,
   input  wire logic               rst_n,
   input  wire logic               wr_en,
   input  wire vrf_pkg::vrf_wr_t   wr,
   input  wire logic               rd0_en,
   input  wire vrf_pkg::vrf_addr_t rd0_addr,
   input  wire logic               rd1_en,
   input  wire vrf_pkg::vrf_addr_t rd1_addr,
   output vrf_pkg::elem_t          rd0_data,
   output vrf_pkg::elem_t          rd1_data,
   input  wire logic               ld_req,
   input  wire vrf_pkg::ld_cmd_t   ld_cmd,
   output logic                    ld_ack,
   output logic                    mem_req,
   output vrf_pkg::mem_addr_t      mem_addr,
   input  wire logic               mem_ack,
   input  wire vrf_pkg::elem_t     mem_rdata
);

   // write port 1, owned by the load unit
   logic             ld_wr_en;
   vrf_pkg::vrf_wr_t ld_wr;

   vector_register_file #(
      .VLEN    (VLEN),
      .V_LANES (V_LANES)
   ) vrf_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .wr_en    (wr_en),
      .wr       (wr),
      .ld_wr_en (ld_wr_en),
      .ld_wr    (ld_wr),
      .rd0_en   (rd0_en),
      .rd0_addr (rd0_addr),
      .rd1_en   (rd1_en),
      .rd1_addr (rd1_addr),
      .rd0_data (rd0_data),
      .rd1_data (rd1_data)
   );

   vector_load_unit load_unit_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .ld_req    (ld_req),
      .ld_cmd    (ld_cmd),
      .ld_ack    (ld_ack),
      .mem_req   (mem_req),
      .mem_addr  (mem_addr),
      .mem_ack   (mem_ack),
      .mem_rdata (mem_rdata),
      .ld_wr_en  (ld_wr_en),
      .ld_wr     (ld_wr)
   );

endmodule

`default_nettype wire

//--- testbench/mem_responder.sv
`timescale 1ns/1ns
`default_nettype none

module mem_responder (
   input  wire logic               clk,
   input  wire logic               rst_n,
   input  wire logic               mem_req,
   input  wire vrf_pkg::mem_addr_t mem_addr,
   output logic                    mem_ack,
   output vrf_pkg::elem_t          mem_rdata
);

   int             seed    = 84067;
   logic           ack_q   = 1'b0;
   logic [1:0]     delay_q = '0;
   vrf_pkg::elem_t rdata_q = '0;

   always @(posedge clk)
   begin
      if (!rst_n)
      begin
         ack_q   <= 1'b0;
         delay_q <= '0;
      end
      else if (ack_q)
      begin
         // release once the request has dropped
         if (!mem_req)
            ack_q <= 1'b0;
      end
      else if (mem_req)
      begin
         if (delay_q == '0)
         begin
            ack_q   <= 1'b1;
            rdata_q <= mem_addr ^ 32'hA5A5_0000;
         end
         else
            delay_q <= delay_q - 2'd1;
      end
      else
         // next answer comes 0 to 3 cycles late
         delay_q <= 2'($random(seed));
   end

   assign mem_ack   = ack_q;
   assign mem_rdata = rdata_q;

endmodule

`default_nettype wire

//--- testbench/vrf_tb.sv
`timescale 1ns/1ns
`default_nettype none

module vrf_tb;

   localparam int VLEN       = 512;
   localparam int V_LANES    = 4;
   localparam int ELEMS      = VLEN / 32;
   localparam int EBITS      = $clog2(ELEMS);
   localparam int LOAD_ELEMS = 20;
   localparam vrf_pkg::elem_t PATTERN = 32'hA5A5_0000;

   logic               clk = 1'b0;
   logic               rst_n;
   logic               wr_en;
   vrf_pkg::vrf_wr_t   wr;
   logic               rd0_en;
   vrf_pkg::vrf_addr_t rd0_addr;
   logic               rd1_en;
   vrf_pkg::vrf_addr_t rd1_addr;
   vrf_pkg::elem_t     rd0_data;
   vrf_pkg::elem_t     rd1_data;
   logic               ld_req;
   vrf_pkg::ld_cmd_t   ld_cmd;
   logic               ld_ack;
   logic               mem_req;
   vrf_pkg::mem_addr_t mem_addr;
   logic               mem_ack;
   vrf_pkg::elem_t     mem_rdata;

   // reference model, indexed [register][element]
   vrf_pkg::elem_t     model [32][ELEMS];
   vrf_pkg::elem_t     exp0;
   vrf_pkg::elem_t     exp1;
   vrf_pkg::vreg_idx_t ld_vreg_m;
   vrf_pkg::mem_addr_t ld_base_m;
   int unsigned        ld_idx;
   logic               word_held;
   int                 seed = 84067;

   vrf_subsystem_top #(.VLEN(VLEN), .V_LANES(V_LANES)) vrf_subsystem_top_inst (
      .clk(clk), .rst_n(rst_n), .wr_en(wr_en), .wr(wr),
      .rd0_en(rd0_en), .rd0_addr(rd0_addr), .rd1_en(rd1_en), .rd1_addr(rd1_addr),
      .rd0_data(rd0_data), .rd1_data(rd1_data), .ld_req(ld_req), .ld_cmd(ld_cmd),
      .ld_ack(ld_ack), .mem_req(mem_req), .mem_addr(mem_addr), .mem_ack(mem_ack),
      .mem_rdata(mem_rdata)
   );

   mem_responder mem_inst (
      .clk(clk), .rst_n(rst_n), .mem_req(mem_req), .mem_addr(mem_addr),
      .mem_ack(mem_ack), .mem_rdata(mem_rdata)
   );

   initial
   begin
      forever #5 clk = ~clk;
   end

   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("Simulation FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   function automatic vrf_pkg::vrf_addr_t elem_addr(input int v, input int e);
      vrf_pkg::vrf_addr_t a;
      a.vreg = vrf_pkg::vreg_idx_t'(v);
      a.elem = vrf_pkg::elem_idx_t'(e);
      return a;
   endfunction

   // one cycle of port activity
   task automatic drive_ports(input logic we, input vrf_pkg::vrf_wr_t w,
                              input logic re0, input vrf_pkg::vrf_addr_t a0,
                              input logic re1, input vrf_pkg::vrf_addr_t a1);
      @(posedge clk);
      wr_en    <= we;
      wr       <= w;
      rd0_en   <= re0;
      rd0_addr <= a0;
      rd1_en   <= re1;
      rd1_addr <= a1;
   endtask

   task automatic run_load(input int v, input vrf_pkg::mem_addr_t base, input int count);
      ld_vreg_m = vrf_pkg::vreg_idx_t'(v);
      ld_base_m = base;
      @(posedge clk);
      ld_req <= 1'b1;
      ld_cmd <= '{vreg: ld_vreg_m, base: base, count: vrf_pkg::vl_count_t'(count)};
      do
         @(posedge clk);
      while (!ld_ack);
      ld_req <= 1'b0;
      do
         @(posedge clk);
      while (ld_ack);
   endtask

   // model follows the port rules, a loaded word lands once ack drops
   always @(posedge clk)
   begin
      if (!rst_n)
      begin
         ld_idx    <= 0;
         word_held <= 1'b0;
      end
      else
      begin
         if (rd0_en)
            exp0 <= model[rd0_addr.vreg][rd0_addr.elem[EBITS-1:0]];
         if (rd1_en)
            exp1 <= model[rd1_addr.vreg][rd1_addr.elem[EBITS-1:0]];
         if (wr_en)
            model[wr.addr.vreg][wr.addr.elem[EBITS-1:0]] <= wr.data;
         if (mem_req && mem_ack)
            word_held <= 1'b1;
         else if (word_held && !mem_ack)
         begin
            // comes after the external write so port 1 wins
            model[ld_vreg_m][ld_idx[EBITS-1:0]] <= (ld_base_m + 32'(ld_idx) * 32'd4) ^ PATTERN;
            ld_idx    <= ld_idx + 1;
            word_held <= 1'b0;
         end
         if (ld_ack)
            ld_idx <= 0;
      end
   end

   a_reset_state: assert property (@(posedge clk)
      $rose(rst_n) |-> !ld_ack && !mem_req && (rd0_data == '0) && (rd1_data == '0))
      else stop_with_error($sformatf("[FAIL] after reset ld_ack=%h mem_req=%h rd0_data=%h rd1_data=%h",
         $sampled(ld_ack), $sampled(mem_req), $sampled(rd0_data), $sampled(rd1_data)));

   a_rd0: assert property (@(posedge clk) disable iff (!rst_n) rd0_en |=> rd0_data == exp0)
      else stop_with_error($sformatf("[FAIL] rd0_data got %h expected %h",
         $sampled(rd0_data), $sampled(exp0)));

   a_rd1: assert property (@(posedge clk) disable iff (!rst_n) rd1_en |=> rd1_data == exp1)
      else stop_with_error($sformatf("[FAIL] rd1_data got %h expected %h",
         $sampled(rd1_data), $sampled(exp1)));

   a_mem_release: assert property (@(posedge clk) disable iff (!rst_n)
      mem_req && mem_ack |=> !mem_req)
      else stop_with_error("mem_req stayed high after the memory acknowledged");

   a_cmd_release: assert property (@(posedge clk) disable iff (!rst_n)
      ld_ack && !ld_req |=> !ld_ack)
      else stop_with_error("ld_ack stayed high after ld_req dropped");

   initial
   begin
      repeat (200 * LOAD_ELEMS + 2000) @(posedge clk);
      stop_with_error("watchdog expired before the tests finished");
   end

   initial
   begin
      vrf_pkg::vrf_addr_t a;
      vrf_pkg::elem_t     d;
      rst_n     = 1'b0;
      wr_en     = 1'b0;
      wr        = '0;
      rd0_en    = 1'b0;
      rd0_addr  = '0;
      rd1_en    = 1'b0;
      rd1_addr  = '0;
      ld_req    = 1'b0;
      ld_cmd    = '0;
      ld_vreg_m = '0;
      ld_base_m = '0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      repeat (2) @(posedge clk);

      // fill every element, then scatter random overwrites
      for (int v = 0; v < 32; v++)
      begin
         for (int e = 0; e < ELEMS; e++)
         begin
            d = vrf_pkg::elem_t'($random(seed));
            drive_ports(1'b1, '{addr: elem_addr(v, e), data: d}, 1'b0, '0, 1'b0, '0);
         end
      end
      repeat (200)
      begin
         a = elem_addr($random(seed) & 31, $random(seed) & (ELEMS - 1));
         d = vrf_pkg::elem_t'($random(seed));
         drive_ports(1'b1, '{addr: a, data: d}, 1'b0, '0, 1'b0, '0);
      end
      // port 1 walks the file backwards
      for (int v = 0; v < 32; v++)
      begin
         for (int e = 0; e < ELEMS; e++)
            drive_ports(1'b0, '0, 1'b1, elem_addr(v, e), 1'b1, elem_addr(31 - v, ELEMS - 1 - e));
      end

      // read during the write sees the old word, next cycle the new one
      a = elem_addr(7, 6);
      drive_ports(1'b1, '{addr: a, data: 32'h0BAD_F00D}, 1'b1, a, 1'b1, a);
      drive_ports(1'b0, '0, 1'b1, a, 1'b1, a);
      drive_ports(1'b0, '0, 1'b0, '0, 1'b0, '0);

      run_load(3, 32'h0000_0100, 16);
      for (int e = 0; e < ELEMS; e++)
         drive_ports(1'b0, '0, 1'b1, elem_addr(3, e), 1'b1, elem_addr(3, ELEMS - 1 - e));
      drive_ports(1'b0, '0, 1'b0, '0, 1'b0, '0);

      // external write lands on the same edge as loaded word 2
      fork
         run_load(5, 32'h0000_0200, 4);
         begin
            repeat (3)
            begin
               do
                  @(posedge clk);
               while (!(mem_ack && !mem_req));
            end
            wr_en <= 1'b1;
            wr    <= '{addr: elem_addr(5, 2), data: 32'h5555_AAAA};
            @(posedge clk);
            wr_en <= 1'b0;
         end
      join
      a = elem_addr(5, 2);
      drive_ports(1'b0, '0, 1'b1, a, 1'b1, elem_addr(5, 3));
      drive_ports(1'b1, '{addr: a, data: 32'h1357_9BDF}, 1'b0, '0, 1'b0, '0);
      drive_ports(1'b0, '0, 1'b1, a, 1'b1, a);
      drive_ports(1'b0, '0, 1'b0, '0, 1'b0, '0);

      repeat (4) @(posedge clk);
      $display("Simulation PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
design/vrf_pkg.sv
design/vrf_bank_ram.sv
design/lvt_table.sv
design/vrf_lane.sv
design/vector_register_file.sv
design/vector_load_unit.sv
design/vrf_subsystem_top.sv
testbench/mem_responder.sv
testbench/vrf_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it
# the exit status is the simulation result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module vrf_tb -f verilog.f -o vrf_tb_sim
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "verilator build failed with status $build_status"
   exit $build_status
fi

./obj_dir/vrf_tb_sim
run_status=$?
if [ $run_status -ne 0 ]; then
   echo "simulation ended with status $run_status"
   exit $run_status
fi

exit 0
